/* Makefile */
# Verilator build and run of the upstream packer testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := upstream_tb
FILELIST  := sdr_upstream.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/sdr_upstream_top.sv */
// FIFO_DEPTH is a power of two up to 1024, since the packer takes 11-bit counts
`default_nettype none
`timescale 1ns/10ps

module sdr_upstream_top
  import upstream_pkg::*;
#(
  parameter logic [7:0] BOARD_NR    = 8'h00,
  parameter logic [7:0] SERIAL_NO   = 8'h00,
  parameter logic [7:0] HARD_STATUS = 8'h40,
  parameter int         FIFO_DEPTH  = 1024
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        have_ip,
  input  logic        run,
  input  logic        wide_spectrum,
  input  logic        idhermeslite,
  input  logic [47:0] mac,
  input  logic        discovery,
  input  logic        udp_tx_enable,
  input  iq_sample_t  iq_data,
  input  logic        iq_last,
  input  logic        iq_mic,
  input  logic        iq_strobe,
  input  bs_sample_t  bs_data,
  input  logic        bs_strobe,
  input  cmd_addr_t   cmd_addr,
  input  logic [31:0] cmd_data,
  input  logic        cmd_rqst,
  input  logic [39:0] resp,
  output logic        udp_tx_request,
  output udp_len_t    udp_tx_length,
  output udp_byte_t   udp_tx_data,
  output logic        resp_rqst
);

  logic [25:0] iq_word;  // Mic, last, sample
  logic        iq_valid;
  logic        iq_pop;
  udp_len_t    iq_count;
  bs_sample_t  bs_sample;
  logic        bs_valid;
  logic        bs_pop;
  udp_len_t    bs_count;
  logic [6:0]  bs_interval;
  logic        vna;

  stream_fifo #(
    .WIDTH($bits(iq_sample_t) + 2),
    .DEPTH(FIFO_DEPTH)
  ) i_iq_fifo (
    .clk(clk), .reset(reset),
    .wr_data({iq_mic, iq_last, iq_data}), .wr_strobe(iq_strobe),
    .rd_pop(iq_pop), .rd_data(iq_word), .rd_valid(iq_valid), .count(iq_count)
  );

  stream_fifo #(
    .WIDTH($bits(bs_sample_t)),
    .DEPTH(FIFO_DEPTH)
  ) i_bs_fifo (
    .clk(clk), .reset(reset),
    .wr_data(bs_data), .wr_strobe(bs_strobe),
    .rd_pop(bs_pop), .rd_data(bs_sample), .rd_valid(bs_valid), .count(bs_count)
  );

  upstream_ctrl_regs i_ctrl_regs (
    .clk(clk), .reset(reset),
    .cmd_addr(cmd_addr), .cmd_data(cmd_data), .cmd_rqst(cmd_rqst),
    .bs_interval(bs_interval), .vna(vna)
  );

  upstream_packer #(
    .BOARD_NR(BOARD_NR), .SERIAL_NO(SERIAL_NO), .HARD_STATUS(HARD_STATUS)
  ) i_packer (
    .clk(clk), .reset(reset), .have_ip(have_ip), .run(run),
    .wide_spectrum(wide_spectrum), .idhermeslite(idhermeslite), .mac(mac),
    .discovery(discovery), .udp_tx_enable(udp_tx_enable),
    .iq_word(iq_word), .iq_valid(iq_valid), .iq_count(iq_count),
    .bs_sample(bs_sample), .bs_valid(bs_valid), .bs_count(bs_count),
    .bs_interval(bs_interval), .vna(vna), .resp(resp),
    .udp_tx_request(udp_tx_request), .udp_tx_length(udp_tx_length),
    .udp_tx_data(udp_tx_data), .iq_pop(iq_pop), .bs_pop(bs_pop), .resp_rqst(resp_rqst)
  );

endmodule

`default_nettype wire

/* logic/stream_fifo.sv */
// DEPTH must be a power of two; writes while full are lost, pops while empty do nothing
`default_nettype none
`timescale 1ns/10ps

module stream_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 1024
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [WIDTH-1:0]       wr_data,
  input  logic                   wr_strobe,
  input  logic                   rd_pop,
  output logic [WIDTH-1:0]       rd_data,
  output logic                   rd_valid,
  output logic [$clog2(DEPTH):0] count
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic             do_write;
  logic             do_read;

  assign rd_valid = (count != '0);
  assign do_write = wr_strobe && (count != (AW+1)'(DEPTH));
  assign do_read  = rd_pop && rd_valid;

  // Head of queue, moves on the cycle after a pop
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/upstream_ctrl_regs.sv */
// Only addresses 0 and 9 are decoded; an interval wider than 7 bits wraps
`default_nettype none
`timescale 1ns/10ps

module upstream_ctrl_regs
  import upstream_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  cmd_addr_t  cmd_addr,
  input  logic [31:0] cmd_data,
  input  logic       cmd_rqst,
  output logic [6:0] bs_interval,
  output logic       vna
);

  cmd_word_u cmd_word;

  assign cmd_word = cmd_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      bs_interval <= 7'd1;
      vna         <= 1'b0;
    end else if (cmd_rqst) begin
      case (cmd_addr)
        CMD_ADDR_RX_CFG: begin
          // Receivers scaled by sample speed
          bs_interval <= (7'(cmd_word.rx_cfg.nrx_m1) + 7'd1) << cmd_word.rx_cfg.speed;
        end
        CMD_ADDR_VNA: begin
          vna <= cmd_word.vna_cfg.vna_en;
        end
        default: begin
          bs_interval <= bs_interval;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/upstream_packer.sv */
// FIFO counts are 11 bits; once udp_tx_enable is seen the byte stream runs without pause
`default_nettype none
`timescale 1ns/10ps

module upstream_packer
  import upstream_pkg::*;
#(
  parameter logic [7:0] BOARD_NR    = 8'h00,
  parameter logic [7:0] SERIAL_NO   = 8'h00,
  parameter logic [7:0] HARD_STATUS = 8'h40
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        have_ip,
  input  logic        run,
  input  logic        wide_spectrum,
  input  logic        idhermeslite,
  input  logic [47:0] mac,
  input  logic        discovery,
  input  logic        udp_tx_enable,
  input  logic [25:0] iq_word,
  input  logic        iq_valid,
  input  udp_len_t    iq_count,
  input  bs_sample_t  bs_sample,
  input  logic        bs_valid,
  input  udp_len_t    bs_count,
  input  logic [6:0]  bs_interval,
  input  logic        vna,
  input  logic [39:0] resp,
  output logic        udp_tx_request,
  output udp_len_t    udp_tx_length,
  output udp_byte_t   udp_tx_data,
  output logic        iq_pop,
  output logic        bs_pop,
  output logic        resp_rqst
);

  localparam logic [3:0] S_IDLE  = 4'd0;
  localparam logic [3:0] S_REQ   = 4'd1;
  localparam logic [3:0] S_DISC  = 4'd2;
  localparam logic [3:0] S_HDR   = 4'd3;
  localparam logic [3:0] S_SYNC  = 4'd4;
  localparam logic [3:0] S_RX2   = 4'd5;
  localparam logic [3:0] S_RX1   = 4'd6;
  localparam logic [3:0] S_RX0   = 4'd7;
  localparam logic [3:0] S_MIC1  = 4'd8;
  localparam logic [3:0] S_MIC0  = 4'd9;
  localparam logic [3:0] S_PAD   = 4'd10;
  localparam logic [3:0] S_BS_LO = 4'd11;
  localparam logic [3:0] S_BS_HI = 4'd12;

  localparam logic [1:0] K_DISC = 2'd0;
  localparam logic [1:0] K_IQ   = 2'd1;
  localparam logic [1:0] K_BS   = 2'd2;

  logic [3:0] state;
  logic [1:0] kind;
  udp_len_t   pos;        // Position of the byte now on udp_tx_data, 0 is the last
  seq_no_t    iq_seq;
  seq_no_t    bs_seq;
  logic [6:0] bs_cnt;
  logic [6:0] round_cnt;
  logic       mic_bit;
  udp_byte_t  data_next;
  udp_byte_t  board_id;
  udp_byte_t  hdr_ep;
  seq_no_t    hdr_seq;
  logic [8:0] frame_pos;
  logic       round_fits;
  logic       start_iq;
  logic       start_bs;

  assign board_id  = idhermeslite ? 8'h06 : 8'h01;
  assign hdr_ep    = (kind == K_BS) ? EP_BS : EP_IQ;
  assign hdr_seq   = (kind == K_BS) ? bs_seq : iq_seq;
  assign frame_pos = pos[8:0];

  // Room left in this frame for one more round of the same size
  assign round_fits = (frame_pos - 9'd1) >= ({2'b00, round_cnt} + 9'd1);

  assign start_iq = (iq_count >= IQ_START_WORDS) && have_ip && run;
  assign start_bs = wide_spectrum && (bs_cnt == '0) && (bs_count >= BS_PACKET_SAMPLES);

  assign udp_tx_request = (state == S_REQ);
  assign iq_pop = (state == S_RX0) && iq_valid;     // After the low byte
  assign bs_pop = (state == S_BS_HI) && bs_valid;

  // Byte for the next position
  always_comb begin
    data_next = udp_tx_data;
    case (state)
      S_REQ: data_next = 8'hEF;
      S_DISC: begin
        case (pos[5:0])
          6'd59:   data_next = 8'hFE;
          6'd58:   data_next = run ? 8'h03 : 8'h02;
          6'd57:   data_next = mac[47:40];
          6'd56:   data_next = mac[39:32];
          6'd55:   data_next = mac[31:24];
          6'd54:   data_next = mac[23:16];
          6'd53:   data_next = mac[15:8];
          6'd52:   data_next = mac[7:0];
          6'd51:   data_next = SERIAL_NO;
          6'd49:   data_next = "H";
          6'd48:   data_next = "E";
          6'd47:   data_next = "R";
          6'd46:   data_next = "M";
          6'd45:   data_next = "E";
          6'd44:   data_next = "S";
          6'd43:   data_next = "L";
          6'd42:   data_next = "T";
          6'd41:   data_next = BOARD_NR;
          6'd38:   data_next = HARD_STATUS;
          default: data_next = board_id;
        endcase
      end
      S_HDR: begin
        case (pos[2:0])
          3'd7:    data_next = 8'hFE;
          3'd6:    data_next = 8'h01;
          3'd5:    data_next = hdr_ep;
          3'd4:    data_next = hdr_seq[31:24];
          3'd3:    data_next = hdr_seq[23:16];
          3'd2:    data_next = hdr_seq[15:8];
          3'd1:    data_next = hdr_seq[7:0];
          default: data_next = 8'h00;
        endcase
      end
      S_SYNC: begin
        case (frame_pos)
          9'h000, 9'h1FF, 9'h1FE: data_next = 8'h7F;
          9'h1FD:  data_next = resp[39:32];
          9'h1FC:  data_next = resp[31:24];
          9'h1FB:  data_next = resp[23:16];
          9'h1FA:  data_next = resp[15:8];
          9'h1F9:  data_next = resp[7:0];
          default: data_next = 8'h00;
        endcase
      end
      S_RX2:   data_next = iq_word[23:16];
      S_RX1:   data_next = iq_word[15:8];
      S_RX0:   data_next = iq_word[7:0];
      S_MIC1:  data_next = 8'h00;
      S_MIC0:  data_next = vna ? {7'h00, mic_bit} : 8'h00;
      S_PAD:   data_next = 8'h00;
      S_BS_LO: data_next = {bs_sample[3:0], 4'h0};
      S_BS_HI: data_next = bs_sample[11:4];
      default: data_next = udp_tx_data;
    endcase
  end

  always_ff @(posedge clk) begin
    udp_tx_data <= data_next;
    if (state == S_RX2) begin
      mic_bit <= iq_word[25];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= S_IDLE;
      kind          <= K_DISC;
      pos           <= '0;
      udp_tx_length <= '0;
      iq_seq        <= '0;
      bs_seq        <= '0;
      bs_cnt        <= 7'd1;
      round_cnt     <= '0;
      resp_rqst     <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (discovery) begin
            kind          <= K_DISC;
            udp_tx_length <= DISCOVERY_LEN;
            state         <= S_REQ;
          end else if (start_iq) begin
            kind          <= K_IQ;
            udp_tx_length <= DATA_PACKET_LEN;
            state         <= S_REQ;
            if (bs_cnt != '0) begin
              bs_cnt <= bs_cnt - 7'd1;
            end
          end else if (start_bs) begin
            kind          <= K_BS;
            udp_tx_length <= DATA_PACKET_LEN;
            bs_cnt        <= bs_interval;  // Next bandscope after this many IQ packets
            state         <= S_REQ;
          end
        end
        S_REQ: begin
          if (udp_tx_enable) begin
            pos   <= udp_tx_length - 11'd1;
            state <= (kind == K_DISC) ? S_DISC : S_HDR;
          end
        end
        default: begin
          pos <= pos - 11'd1;
          if (pos == '0) begin
            state <= S_IDLE;
          end else begin
            case (state)
              S_DISC, S_PAD: state <= state;
              S_HDR: begin
                if (pos[2:0] == 3'd1) begin
                  if (kind == K_BS) begin
                    bs_seq <= bs_seq + 32'd1;
                    state  <= S_BS_LO;
                  end else begin
                    iq_seq <= iq_seq + 32'd1;
                    state  <= S_SYNC;
                  end
                end
              end
              S_SYNC: begin
                round_cnt <= '0;
                if (frame_pos == FRAME_DATA_BYTES + 9'd1) begin
                  resp_rqst <= ~resp_rqst;
                  state     <= S_RX2;
                end
              end
              S_RX2: begin
                round_cnt <= round_cnt + 7'd1;
                state     <= S_RX1;
              end
              S_RX1: begin
                round_cnt <= round_cnt + 7'd1;
                state     <= S_RX0;
              end
              S_RX0: begin
                round_cnt <= round_cnt + 7'd1;
                state     <= iq_word[24] ? S_MIC1 : S_RX2;  // Last receiver of the round
              end
              S_MIC1: begin
                round_cnt <= round_cnt + 7'd1;
                state     <= S_MIC0;
              end
              S_MIC0: begin
                round_cnt <= '0;
                state     <= round_fits ? S_RX2 : S_PAD;
              end
              S_BS_LO: state <= S_BS_HI;
              S_BS_HI: state <= S_BS_LO;
              default: state <= S_IDLE;
            endcase
            // Frame full, next frame begins with sync
            if (frame_pos == 9'd1 && state >= S_RX2 && state <= S_PAD) begin
              state <= S_SYNC;
            end
          end
        end
      endcase
      if (!run) begin
        iq_seq <= '0;
        bs_seq <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/upstream_pkg.sv */
// Lengths count UDP payload bytes; the IQ start threshold assumes at most 12 receivers
`default_nettype none

package upstream_pkg;

  typedef logic [7:0]  udp_byte_t;
  typedef logic [10:0] udp_len_t;
  typedef logic [31:0] seq_no_t;
  typedef logic [23:0] iq_sample_t;
  typedef logic [11:0] bs_sample_t;
  typedef logic [5:0]  cmd_addr_t;

  // One command data word, read according to its address
  typedef union packed {
    struct packed {
      logic [5:0]  rsvd_hi;
      logic [1:0]  speed;      // Sample rate code
      logic [15:0] rsvd_mid;
      logic [4:0]  nrx_m1;     // Receivers minus one
      logic [2:0]  rsvd_lo;
    } rx_cfg;
    struct packed {
      logic [7:0]  rsvd_hi;
      logic        vna_en;
      logic [22:0] rsvd_lo;
    } vna_cfg;
  } cmd_word_u;

  localparam udp_len_t DISCOVERY_LEN = 11'd60;
  localparam udp_len_t DATA_PACKET_LEN = 11'd1032;
  localparam logic [8:0] FRAME_DATA_BYTES = 9'd504;  // 512 byte frame less its header
  localparam udp_len_t BS_PACKET_SAMPLES = 11'd512;
  localparam udp_len_t IQ_START_WORDS = 11'd334;

  localparam cmd_addr_t CMD_ADDR_RX_CFG = 6'd0;
  localparam cmd_addr_t CMD_ADDR_VNA = 6'd9;

  localparam udp_byte_t EP_IQ = 8'd6;
  localparam udp_byte_t EP_BS = 8'd4;

endpackage

`default_nettype wire

/* sdr_upstream.f */
+incdir+tests
logic/upstream_pkg.sv
logic/stream_fifo.sv
logic/upstream_ctrl_regs.sv
logic/upstream_packer.sv
logic/sdr_upstream_top.sv
tests/upstream_tb.sv

/* tests/upstream_checks.svh */
// Included inside upstream_tb, which supplies clk, the DUT signals, pkt, pkt_len and fail_run
`ifndef UPSTREAM_CHECKS_SVH
`define UPSTREAM_CHECKS_SVH

task automatic check_byte(input string name, input udp_byte_t got, input udp_byte_t exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
    fail_run();
  end
endtask

task automatic check_length(input string name, input udp_len_t got, input udp_len_t exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    fail_run();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    fail_run();
  end
endtask

// UDP transmitter model, grants the request at once and records the payload
task automatic receive_packet();
  while (udp_tx_request !== 1'b1) begin
    @(negedge clk);
  end
  pkt_len = udp_tx_length;
  resp_start = resp_rqst;
  resp_mid = resp_rqst;
  udp_tx_enable = 1'b1;
  @(negedge clk);
  udp_tx_enable = 1'b0;
  for (int i = 0; i < int'(pkt_len); i++) begin
    pkt[i] = udp_tx_data;
    if (i == 520) begin
      resp_mid = resp_rqst;  // First byte of frame 1
    end
    @(negedge clk);
  end
endtask

task automatic check_header(input udp_byte_t ep, input seq_no_t seq);
  check_length("udp_tx_length", pkt_len, DATA_PACKET_LEN);
  check_byte("header byte 0", pkt[0], 8'hEF);
  check_byte("header byte 1", pkt[1], 8'hFE);
  check_byte("header byte 2", pkt[2], 8'h01);
  check_byte("endpoint", pkt[3], ep);
  for (int k = 0; k < 4; k++) begin
    check_byte($sformatf("sequence byte %0d", k), pkt[4 + k], seq[(3 - k) * 8 +: 8]);
  end
endtask

`endif

/* tests/upstream_tb.sv */
// Directed tests with a zero-latency UDP sink; every test starts from a fresh reset
`default_nettype none
`timescale 1ns/10ps

module upstream_tb
  import upstream_pkg::*;
();

  localparam logic [7:0]  BOARD_NR    = 8'h05;
  localparam logic [7:0]  SERIAL_NO   = 8'h4A;
  localparam logic [7:0]  HARD_STATUS = 8'h3C;
  localparam logic [47:0] MAC         = 48'h00_1C_C0_A2_13_5D;
  localparam logic [39:0] RESP        = 40'h81_22_33_44_95;
  // Twelve packets of about 1040 cycles plus FIFO fills and idle waits
  localparam int TIMEOUT_CYCLES = 12 * 1040 + 17520;

  logic        clk;
  logic        reset;
  logic        have_ip;
  logic        run;
  logic        wide_spectrum;
  logic        idhermeslite;
  logic [47:0] mac;
  logic        discovery;
  logic        udp_tx_enable;
  iq_sample_t  iq_data;
  logic        iq_last;
  logic        iq_mic;
  logic        iq_strobe;
  bs_sample_t  bs_data;
  logic        bs_strobe;
  cmd_addr_t   cmd_addr;
  logic [31:0] cmd_data;
  logic        cmd_rqst;
  logic [39:0] resp;
  logic        udp_tx_request;
  udp_len_t    udp_tx_length;
  udp_byte_t   udp_tx_data;
  logic        resp_rqst;

  udp_byte_t   pkt [2048];
  udp_len_t    pkt_len;
  logic        resp_start;
  logic        resp_mid;
  logic [25:0] iq_model [$];  // Mic, last, sample as written
  bs_sample_t  bs_model [$];
  logic        vna_exp;
  int          cycles = 0;

  sdr_upstream_top #(
    .BOARD_NR(BOARD_NR), .SERIAL_NO(SERIAL_NO), .HARD_STATUS(HARD_STATUS), .FIFO_DEPTH(1024)
  ) i_sdr_upstream_top (
    .clk(clk), .reset(reset), .have_ip(have_ip), .run(run), .wide_spectrum(wide_spectrum),
    .idhermeslite(idhermeslite), .mac(mac), .discovery(discovery),
    .udp_tx_enable(udp_tx_enable), .iq_data(iq_data), .iq_last(iq_last), .iq_mic(iq_mic),
    .iq_strobe(iq_strobe), .bs_data(bs_data), .bs_strobe(bs_strobe), .cmd_addr(cmd_addr),
    .cmd_data(cmd_data), .cmd_rqst(cmd_rqst), .resp(resp), .udp_tx_request(udp_tx_request),
    .udp_tx_length(udp_tx_length), .udp_tx_data(udp_tx_data), .resp_rqst(resp_rqst)
  );

  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  `include "upstream_checks.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      fail_run();
    end
  end

  task automatic apply_reset();
    reset = 1'b1;
    have_ip = 1'b0;
    run = 1'b0;
    wide_spectrum = 1'b0;
    idhermeslite = 1'b1;
    mac = MAC;
    discovery = 1'b0;
    udp_tx_enable = 1'b0;
    iq_data = '0;
    iq_last = 1'b0;
    iq_mic = 1'b0;
    iq_strobe = 1'b0;
    bs_data = '0;
    bs_strobe = 1'b0;
    cmd_addr = '0;
    cmd_data = '0;
    cmd_rqst = 1'b0;
    resp = RESP;
    iq_model.delete();
    bs_model.delete();
    vna_exp = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
  endtask

  task automatic send_command(input cmd_addr_t addr, input logic [31:0] data);
    cmd_addr = addr;
    cmd_data = data;
    cmd_rqst = 1'b1;
    @(negedge clk);
    cmd_rqst = 1'b0;
  endtask

  // Last flag on every nrx-th word closes a round
  task automatic write_iq_words(input int n, input int nrx);
    logic [25:0] w;
    for (int i = 0; i < n; i++) begin
      w = {1'($urandom), (i % nrx) == nrx - 1, 24'($urandom)};
      {iq_mic, iq_last, iq_data} = w;
      iq_strobe = 1'b1;
      iq_model.push_back(w);
      @(negedge clk);
    end
    iq_strobe = 1'b0;
  endtask

  task automatic write_bs_samples(input int n);
    for (int i = 0; i < n; i++) begin
      bs_data = 12'($urandom);
      bs_strobe = 1'b1;
      bs_model.push_back(bs_data);
      @(negedge clk);
    end
    bs_strobe = 1'b0;
  endtask

  function automatic udp_byte_t discovery_byte(input int i, input logic run_bit,
                                               input logic hl_bit);
    string id_text = "HERMESLT";
    case (i) inside
      0:       return 8'hEF;
      1:       return 8'hFE;
      2:       return run_bit ? 8'h03 : 8'h02;
      [3:8]:   return MAC[(8 - i) * 8 +: 8];
      9:       return SERIAL_NO;
      [11:18]: return udp_byte_t'(id_text[i - 11]);
      19:      return BOARD_NR;
      22:      return HARD_STATUS;
      default: return hl_bit ? 8'h06 : 8'h01;  // Board id
    endcase
  endfunction

  task automatic check_iq_packet(input seq_no_t seq, input int nrx, input int rounds);
    int p;
    int frame_end;
    logic [25:0] w;
    check_header(EP_IQ, seq);
    check_bit("resp_rqst after frame 0", resp_mid, ~resp_start);
    check_bit("resp_rqst after frame 1", resp_rqst, resp_start);
    for (int f = 0; f < 2; f++) begin
      p = 8 + f * 512;
      frame_end = p + 512;
      for (int k = 0; k < 8; k++) begin
        check_byte($sformatf("frame %0d sync byte %0d", f, k), pkt[p + k],
                   (k < 3) ? 8'h7F : resp[(7 - k) * 8 +: 8]);
      end
      p = p + 8;
      for (int r = 0; r < rounds; r++) begin
        for (int k = 0; k < nrx; k++) begin
          w = iq_model.pop_front();
          for (int b = 0; b < 3; b++) begin
            check_byte($sformatf("udp_tx_data[%0d]", p + b), pkt[p + b], w[(2 - b) * 8 +: 8]);
          end
          p = p + 3;
        end
        check_byte($sformatf("udp_tx_data[%0d]", p), pkt[p], 8'h00);
        check_byte($sformatf("mic byte %0d", p + 1), pkt[p + 1], {7'h00, vna_exp & w[25]});
        p = p + 2;
      end
      while (p < frame_end) begin
        check_byte($sformatf("padding byte %0d", p), pkt[p], 8'h00);
        p++;
      end
    end
  endtask

  task automatic test_discovery();
    apply_reset();
    for (int c = 3; c >= 0; c--) begin
      run = c[0];
      idhermeslite = c[1];
      discovery = 1'b1;
      @(negedge clk);
      discovery = 1'b0;
      receive_packet();
      check_length("udp_tx_length", pkt_len, DISCOVERY_LEN);
      for (int i = 0; i < int'(DISCOVERY_LEN); i++) begin
        check_byte($sformatf("discovery byte %0d", i), pkt[i],
                   discovery_byte(i, run, idhermeslite));
      end
    end
  endtask

  task automatic test_iq_packet();
    apply_reset();
    have_ip = 1'b1;
    run = 1'b1;
    send_command(CMD_ADDR_RX_CFG, 32'(1) << 3);  // Two receivers
    send_command(CMD_ADDR_VNA, 32'(1) << 23);
    vna_exp = 1'b1;
    write_iq_words(400, 2);
    receive_packet();
    check_iq_packet(0, 2, 63);
  endtask

  // 11-byte rounds leave 9 bytes of padding per frame
  task automatic test_round_padding();
    apply_reset();
    have_ip = 1'b1;
    run = 1'b1;
    send_command(CMD_ADDR_RX_CFG, 32'(2) << 3);
    write_iq_words(339, 3);
    receive_packet();
    check_iq_packet(0, 3, 45);
  endtask

  task automatic test_sequence_run();
    apply_reset();
    have_ip = 1'b1;
    run = 1'b1;
    write_iq_words(504, 2);
    receive_packet();
    check_iq_packet(0, 2, 63);
    write_iq_words(100, 2);  // 352 words is enough for one more
    receive_packet();
    check_iq_packet(1, 2, 63);
    run = 1'b0;
    repeat (4) @(negedge clk);
    run = 1'b1;
    write_iq_words(252, 2);
    receive_packet();
    check_iq_packet(0, 2, 63);
  endtask

  task automatic test_bandscope();
    bs_sample_t s;
    apply_reset();
    have_ip = 1'b1;
    run = 1'b1;
    wide_spectrum = 1'b1;
    write_bs_samples(512);
    write_iq_words(334, 2);
    receive_packet();
    check_iq_packet(0, 2, 63);
    receive_packet();
    check_header(EP_BS, 0);
    for (int i = 0; i < 512; i++) begin
      s = bs_model.pop_front();
      check_byte($sformatf("sample %0d low byte", i), pkt[8 + 2 * i], {s[3:0], 4'h0});
      check_byte($sformatf("sample %0d high byte", i), pkt[9 + 2 * i], s[11:4]);
    end
  endtask

  task automatic test_ip_gating();
    apply_reset();
    run = 1'b1;
    write_iq_words(400, 2);
    repeat (200) begin
      check_bit("udp_tx_request", udp_tx_request, 1'b0);
      @(negedge clk);
    end
    have_ip = 1'b1;
    receive_packet();
    check_header(EP_IQ, 0);
  endtask

  initial begin
    void'($urandom(9));
    test_discovery();
    test_iq_packet();
    test_round_padding();
    test_sequence_run();
    test_bandscope();
    test_ip_gating();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
